// File: cpu_pkg.sv
// Shared widths, data types, opcode encoding, address map and FSM state types of the CPU
`default_nettype none

package cpu_pkg;

   localparam int DATA_W     = 16;   // Accumulator, RAM and port word width
   localparam int OPC_W      = 5;    // Opcode field at the top of the instruction
   localparam int ADDR_W     = 11;   // Operand, data address and PC width
   localparam int INSTR_W    = OPC_W + ADDR_W; // Full instruction word
   localparam int RAM_AW     = 10;   // RAM index and APB address width
   localparam int RAM_DEPTH  = 1024; // Data RAM entries
   localparam int PERIPH_BIT = 10;   // Address bit that acts as peripheral chip enable

   typedef logic [DATA_W-1:0]  word_t;    // Data word
   typedef logic [INSTR_W-1:0] instr_t;   // Instruction word
   typedef logic [ADDR_W-1:0]  operand_t; // Address or signed immediate
   typedef logic [ADDR_W-1:0]  addr_t;    // Data address, top bit selects peripherals
   typedef logic [ADDR_W-1:0]  pc_t;      // Program counter
   typedef logic [RAM_AW-1:0]  paddr_t;   // APB register address

   // Register map of the two-register port block
   localparam paddr_t OUT_PORT_ADDR = 10'd0; // Output port, read/write
   localparam paddr_t IN_PORT_ADDR  = 10'd1; // Input port, read only with one wait state

   // Instruction set, codes above SUBI decode as halt
   typedef enum logic [OPC_W-1:0] {
      HLT  = 5'd0, // Stop fetching
      STO  = 5'd1, // mem[op] = acc
      LD   = 5'd2, // acc = mem[op]
      LDI  = 5'd3, // acc = sext(op)
      ADD  = 5'd4, // acc += mem[op]
      ADDI = 5'd5, // acc += sext(op)
      SUB  = 5'd6, // acc -= mem[op]
      SUBI = 5'd7  // acc -= sext(op)
   } opcode_e;

   // Core sequencing
   typedef enum logic [1:0] {
      RUN,      // One instruction per cycle
      MEM_WAIT, // Stalled until the bus reports done
      HALT      // Frozen until reset
   } exec_state_e;

   // APB master phases, setup shares the issue cycle
   typedef enum logic [1:0] {
      APB_IDLE,   // No transfer, setup driven straight from the request
      APB_ACCESS, // penable high, waiting for pready
      APB_DONE    // Transfer finished, done back to the core
   } apb_state_e;

endpackage

`default_nettype wire

// File: cpu_ifs.sv
// Decode-to-execute control, core data bus and APB interfaces with their modports
`default_nettype none

// Control word from decode into execute
interface ctrl_if;
   logic              op_ld_acc; // Load accumulator from source
   logic              op_add;    // Add source to accumulator
   logic              op_sub;    // Subtract source from accumulator
   logic              use_imm;   // Source is the immediate, else memory
   logic              mem_rd;    // Instruction reads data space
   logic              mem_wr;    // Instruction writes data space
   logic              halt;      // HLT or unknown opcode
   cpu_pkg::operand_t operand;   // Address or immediate field

   modport decode_mp (output op_ld_acc, op_add, op_sub, use_imm, mem_rd, mem_wr, halt, operand);
   modport exec_mp   (input  op_ld_acc, op_add, op_sub, use_imm, mem_rd, mem_wr, halt, operand);
endinterface

// Core request bus, held by the core until done
interface core_bus_if;
   cpu_pkg::addr_t addr;  // Data address, bit 10 picks peripherals
   cpu_pkg::word_t wdata; // Store data
   logic           rd;    // Read request
   logic           wr;    // Write request
   cpu_pkg::word_t rdata; // Load data, valid with done
   logic           done;  // One-cycle completion strobe

   modport core_mp (output addr, wdata, rd, wr, input rdata, done);
   modport mem_mp  (input addr, wdata, rd, wr, output rdata, done);
endinterface

// APB without PSLVERR
interface apb_if;
   cpu_pkg::paddr_t paddr;
   logic            psel;
   logic            penable;
   logic            pwrite;
   cpu_pkg::word_t  pwdata;
   cpu_pkg::word_t  prdata;
   logic            pready;  // Low stretches the access phase

   modport master_mp (output paddr, psel, penable, pwrite, pwdata, input prdata, pready);
   modport slave_mp  (input paddr, psel, penable, pwrite, pwdata, output prdata, pready);
endinterface

`default_nettype wire

// File: instr_decode.sv
// Combinational instruction decoder from instruction word to control signals and operand
`default_nettype none

module instr_decode (
   input  wire cpu_pkg::instr_t i_instr, // Instruction addressed by the PC
   ctrl_if.decode_mp            ctrl     // Control word into execute
);

   cpu_pkg::opcode_e opcode; // Top field of the instruction

   always_comb begin
      opcode       = cpu_pkg::opcode_e'(i_instr[cpu_pkg::INSTR_W-1 -: cpu_pkg::OPC_W]);
      ctrl.operand = i_instr[cpu_pkg::ADDR_W-1:0]; // Low field, address or immediate
   end

   // Each opcode enables exactly one action group
   always_comb begin
      ctrl.op_ld_acc = 1'b0;
      ctrl.op_add    = 1'b0;
      ctrl.op_sub    = 1'b0;
      ctrl.use_imm   = 1'b0;
      ctrl.mem_rd    = 1'b0;
      ctrl.mem_wr    = 1'b0;
      ctrl.halt      = 1'b0;
      case (opcode)
         cpu_pkg::STO: begin
            ctrl.mem_wr = 1'b1; // Accumulator out to data space
         end
         cpu_pkg::LD: begin
            ctrl.op_ld_acc = 1'b1;
            ctrl.mem_rd    = 1'b1;
         end
         cpu_pkg::LDI: begin
            ctrl.op_ld_acc = 1'b1;
            ctrl.use_imm   = 1'b1;
         end
         cpu_pkg::ADD: begin
            ctrl.op_add = 1'b1;
            ctrl.mem_rd = 1'b1;
         end
         cpu_pkg::ADDI: begin
            ctrl.op_add  = 1'b1;
            ctrl.use_imm = 1'b1;
         end
         cpu_pkg::SUB: begin
            ctrl.op_sub = 1'b1;
            ctrl.mem_rd = 1'b1;
         end
         cpu_pkg::SUBI: begin
            ctrl.op_sub  = 1'b1;
            ctrl.use_imm = 1'b1;
         end
         default: begin
            ctrl.halt = 1'b1; // HLT and every unused code
         end
      endcase
   end

   // A request on the core bus is either a read or a write
   always_comb begin
      a_rd_wr_excl: assert (!(ctrl.mem_rd && ctrl.mem_wr));
   end

endmodule

`default_nettype wire

// File: acc_execute.sv
// Accumulator execute stage with PC, ALU, halt state and memory stall FSM
`default_nettype none

module acc_execute (
   input  wire logic     i_clk,
   input  wire logic     i_reset,
   ctrl_if.exec_mp       ctrl,     // Decoded instruction
   core_bus_if.core_mp   bus,      // Requests to memory and I/O
   output cpu_pkg::pc_t  o_pc,     // Fetch address
   output logic          o_halted  // High after HLT
);

   cpu_pkg::exec_state_e state_q;
   cpu_pkg::pc_t         pc_q;
   cpu_pkg::word_t       acc_q;
   cpu_pkg::word_t       imm_ext;  // Sign-extended operand
   cpu_pkg::word_t       alu_src;
   cpu_pkg::word_t       alu_res;
   logic                 mem_op;
   logic                 acc_wr;
   logic                 retire;   // Instruction completes this cycle

   always_comb begin
      imm_ext = {{(cpu_pkg::DATA_W-cpu_pkg::ADDR_W){ctrl.operand[cpu_pkg::ADDR_W-1]}},
                 ctrl.operand};
      alu_src = ctrl.use_imm ? imm_ext : bus.rdata; // Memory word only valid with done
      if (ctrl.op_ld_acc) begin
         alu_res = alu_src;
      end else if (ctrl.op_add) begin
         alu_res = acc_q + alu_src; // Wraps at 16 bits
      end else if (ctrl.op_sub) begin
         alu_res = acc_q - alu_src;
      end else begin
         alu_res = acc_q;
      end
      acc_wr = ctrl.op_ld_acc | ctrl.op_add | ctrl.op_sub;
      mem_op = ctrl.mem_rd | ctrl.mem_wr;
      retire = ~ctrl.halt & (~mem_op | bus.done); // RAM stores finish at once
   end

   // Request held through MEM_WAIT since the PC and so the instruction hold
   always_comb begin
      bus.rd    = (state_q != cpu_pkg::HALT) & ctrl.mem_rd;
      bus.wr    = (state_q != cpu_pkg::HALT) & ctrl.mem_wr;
      bus.addr  = ctrl.operand;
      bus.wdata = acc_q; // STO data
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state_q <= cpu_pkg::RUN;
         pc_q    <= '0;
         acc_q   <= '0;
      end else begin
         case (state_q)
            cpu_pkg::RUN: begin
               if (ctrl.halt) begin
                  state_q <= cpu_pkg::HALT;     // Sticky until reset
               end else if (!retire) begin
                  state_q <= cpu_pkg::MEM_WAIT; // Load or peripheral access
               end
            end
            cpu_pkg::MEM_WAIT: begin
               if (retire) begin
                  state_q <= cpu_pkg::RUN;
               end
            end
            default: begin
               state_q <= cpu_pkg::HALT;
            end
         endcase
         if ((state_q != cpu_pkg::HALT) && retire) begin
            pc_q <= pc_q + cpu_pkg::pc_t'(1);
            if (acc_wr) begin
               acc_q <= alu_res; // Loads take rdata here
            end
         end
      end
   end

   assign o_pc     = pc_q;
   assign o_halted = (state_q == cpu_pkg::HALT);

   // No fetch advance while the bus access is outstanding
   a_pc_hold: assert property (@(posedge i_clk) disable iff (i_reset)
      (state_q == cpu_pkg::MEM_WAIT && !bus.done) |=> $stable(pc_q));

endmodule

`default_nettype wire

// File: data_memory.sv
// Synchronous single-port data RAM with enable and write strobe
`default_nettype none

module data_memory (
   input  wire logic                        i_clk,
   input  wire logic                        i_en,   // Access this cycle
   input  wire logic                        i_wr,   // Write, else read
   input  wire logic [cpu_pkg::RAM_AW-1:0]  i_addr,
   input  wire cpu_pkg::word_t              i_data,
   output cpu_pkg::word_t                   o_data  // Valid the cycle after a read
);

   cpu_pkg::word_t mem [cpu_pkg::RAM_DEPTH]; // Contents kept across reset

   always_ff @(posedge i_clk) begin
      if (i_en) begin
         if (i_wr) begin
            mem[i_addr] <= i_data;
         end else begin
            o_data <= mem[i_addr]; // Registered read port
         end
      end
   end

endmodule

`default_nettype wire

// File: mem_io.sv
// Memory and I/O stage with RAM/peripheral address decode, APB master and read-data mux
`default_nettype none

module mem_io (
   input  wire logic   i_clk,
   input  wire logic   i_reset,
   core_bus_if.mem_mp  bus, // Requests from execute
   apb_if.master_mp    apb  // Peripheral bus
);

   cpu_pkg::apb_state_e apb_q;
   cpu_pkg::word_t      ram_q;     // RAM read port
   cpu_pkg::word_t      prdata_q;  // Read data captured at transfer end
   logic                periph;    // Top address bit is the peripheral chip enable
   logic                ram_en;
   logic                periph_req;
   logic                ram_rd_q;  // RAM read data ready next cycle

   always_comb begin
      periph     = bus.addr[cpu_pkg::PERIPH_BIT];
      ram_en     = (bus.rd | bus.wr) & ~periph;
      periph_req = (bus.rd | bus.wr) & periph;
   end

   data_memory u_ram (
      .i_clk  (i_clk),
      .i_en   (ram_en),
      .i_wr   (bus.wr),
      .i_addr (bus.addr[cpu_pkg::RAM_AW-1:0]),
      .i_data (bus.wdata),
      .o_data (ram_q)
   );

   // Setup phase shares the issue cycle with the address taken straight from the held request
   always_comb begin
      apb.paddr   = bus.addr[cpu_pkg::RAM_AW-1:0];
      apb.pwrite  = bus.wr;
      apb.pwdata  = bus.wdata;
      apb.psel    = ((apb_q == cpu_pkg::APB_IDLE) & periph_req) | (apb_q == cpu_pkg::APB_ACCESS);
      apb.penable = (apb_q == cpu_pkg::APB_ACCESS);
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         apb_q    <= cpu_pkg::APB_IDLE;
         ram_rd_q <= 1'b0;
      end else begin
         ram_rd_q <= bus.rd & ~periph & ~ram_rd_q; // One strobe per read while the request stays up
         case (apb_q)
            cpu_pkg::APB_IDLE: begin
               if (periph_req) begin
                  apb_q <= cpu_pkg::APB_ACCESS;
               end
            end
            cpu_pkg::APB_ACCESS: begin
               if (apb.pready) begin
                  apb_q <= cpu_pkg::APB_DONE; // Slave may stretch this phase
               end
            end
            default: begin
               apb_q <= cpu_pkg::APB_IDLE; // psel low here while the core moves on
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if ((apb_q == cpu_pkg::APB_ACCESS) && apb.pready) begin
         prdata_q <= apb.prdata;
      end
   end

   always_comb begin
      // RAM writes finish in their own cycle and reads and APB one cycle later
      bus.done  = (bus.wr & ~periph) | ram_rd_q | (apb_q == cpu_pkg::APB_DONE);
      bus.rdata = periph ? prdata_q : ram_q;
   end

   // Access phase only under psel and only after a setup or access cycle
   a_penable_psel: assert property (@(posedge i_clk) disable iff (i_reset)
      apb.penable |-> (apb.psel && $past(apb.psel)));

   // Address must not move during a transfer that has not finished
   a_paddr_hold: assert property (@(posedge i_clk) disable iff (i_reset)
      (apb.psel && !(apb.penable && apb.pready)) |=> $stable(apb.paddr));

endmodule

`default_nettype wire

// File: io_port_apb.sv
// APB slave with an output port register and a wait-stated input port register
`default_nettype none

module io_port_apb (
   input  wire logic            i_clk,
   input  wire logic            i_reset,
   apb_if.slave_mp              apb,
   input  wire cpu_pkg::word_t  i_in_port,  // External input pins
   output cpu_pkg::word_t       o_out_port  // External output pins
);

   cpu_pkg::word_t out_q;
   cpu_pkg::word_t in_q;      // Input sampled in the wait cycle
   logic           acc_phase;
   logic           in_rd;     // Access-phase read of the input port
   logic           wait_q;    // Wait cycle already spent

   always_comb begin
      acc_phase  = apb.psel & apb.penable;
      in_rd      = acc_phase & ~apb.pwrite & (apb.paddr == cpu_pkg::IN_PORT_ADDR);
      apb.pready = ~in_rd | wait_q; // Only input reads stretch
      case (apb.paddr)
         cpu_pkg::OUT_PORT_ADDR: apb.prdata = out_q;
         cpu_pkg::IN_PORT_ADDR:  apb.prdata = in_q;
         default:                apb.prdata = '0; // Unmapped reads as zero
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wait_q <= 1'b0;
         out_q  <= '0;
      end else begin
         wait_q <= in_rd & ~wait_q;
         if (acc_phase && apb.pwrite && (apb.paddr == cpu_pkg::OUT_PORT_ADDR)) begin
            out_q <= apb.pwdata; // Other addresses drop writes
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (in_rd && !wait_q) begin
         in_q <= i_in_port;
      end
   end

   assign o_out_port = out_q;

endmodule

`default_nettype wire

// File: cpu_top.sv
// Top level of the accumulator CPU subsystem with decode, execute, memory/I/O and port block
`default_nettype none

module cpu_top (
   input  wire logic            i_clk,
   input  wire logic            i_reset,
   output cpu_pkg::pc_t         o_pc,       // Program fetch address
   input  wire cpu_pkg::instr_t i_instr,    // Instruction at o_pc
   input  wire cpu_pkg::word_t  i_in_port,
   output cpu_pkg::word_t       o_out_port,
   output logic                 o_halted
);

   ctrl_if     ctrl ();  // Decode to execute
   core_bus_if bus ();   // Execute to memory/I/O
   apb_if      apb ();   // Master to port block

   instr_decode u_decode (
      .i_instr (i_instr),
      .ctrl    (ctrl.decode_mp)
   );

   acc_execute u_execute (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .ctrl     (ctrl.exec_mp),
      .bus      (bus.core_mp),
      .o_pc     (o_pc),
      .o_halted (o_halted)
   );

   mem_io u_mem_io (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .bus     (bus.mem_mp),
      .apb     (apb.master_mp)
   );

   io_port_apb u_io_port (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .apb        (apb.slave_mp),
      .i_in_port  (i_in_port),
      .o_out_port (o_out_port)
   );

endmodule

`default_nettype wire

// File: tb_cpu_top.sv
// Testbench for cpu_top with program table, ISA reference model, LFSR immediates and timeout
`default_nettype none

module tb_cpu_top;

   localparam int NUM_TESTS = 5;
   localparam int PROG_MAX  = 16; // Program words per test

   logic                clk;
   logic                i_reset;
   cpu_pkg::instr_t     i_instr;
   cpu_pkg::word_t      i_in_port;
   cpu_pkg::pc_t        o_pc;
   cpu_pkg::word_t      o_out_port;
   logic                o_halted;

   // Test table
   string               test_name  [NUM_TESTS];
   cpu_pkg::instr_t     prog       [NUM_TESTS][PROG_MAX]; // Padded with HLT
   int                  prog_len   [NUM_TESTS];
   cpu_pkg::word_t      in_val     [NUM_TESTS];           // i_in_port during the test
   logic                hold_check [NUM_TESTS];           // Watch halt, then reset again
   cpu_pkg::word_t      exp_out    [NUM_TESTS];           // From the ISA model
   cpu_pkg::pc_t        exp_pc     [NUM_TESTS];           // HLT address

   int                  cur;            // Test being run
   int                  mismatch_count;
   int                  cycle_count;
   int                  cycle_limit;
   logic [31:0]         lfsr_q;

   cpu_top u_dut (
      .i_clk      (clk),
      .i_reset    (i_reset),
      .o_pc       (o_pc),
      .i_instr    (i_instr),
      .i_in_port  (i_in_port),
      .o_out_port (o_out_port),
      .o_halted   (o_halted)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) return (s >> 1) ^ 32'h8020_0003; // Galois feedback taps
      return s >> 1;
   endfunction

   // One LFSR step per operand bit
   task automatic rand_operand(output logic [10:0] v);
      v = '0;
      repeat (11) begin
         v      = {lfsr_q[0], v[10:1]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   task automatic emit(input int t, input cpu_pkg::opcode_e op, input logic [10:0] opd);
      prog[t][prog_len[t]] = {op, opd};
      prog_len[t]++;
   endtask

   // Instruction-level model stepping one instruction at a time without timing
   task automatic model_run(input int t, output cpu_pkg::word_t out_v, output cpu_pkg::pc_t pc_v);
      cpu_pkg::word_t ram [cpu_pkg::RAM_DEPTH];
      cpu_pkg::word_t acc;
      cpu_pkg::word_t out_reg;
      cpu_pkg::word_t imm;
      cpu_pkg::word_t data;
      logic [4:0]     op;
      logic [10:0]    opd;
      int             pc;
      logic           running;
      acc     = '0;
      out_reg = '0; // Port register starts from reset
      pc      = 0;
      running = 1'b1;
      while (running && pc < PROG_MAX) begin
         op   = prog[t][pc][15:11];
         opd  = prog[t][pc][10:0];
         imm  = {{5{opd[10]}}, opd};
         data = '0; // Unmapped peripheral reads as zero
         if (!opd[10]) data = ram[opd[9:0]];
         else if (opd[9:0] == cpu_pkg::OUT_PORT_ADDR) data = out_reg;
         else if (opd[9:0] == cpu_pkg::IN_PORT_ADDR) data = in_val[t];
         case (op)
            cpu_pkg::STO: begin
               if (!opd[10]) ram[opd[9:0]] = acc;
               else if (opd[9:0] == cpu_pkg::OUT_PORT_ADDR) out_reg = acc;
            end
            cpu_pkg::LD:   acc = data;
            cpu_pkg::LDI:  acc = imm;
            cpu_pkg::ADD:  acc = acc + data; // 16-bit wrap
            cpu_pkg::ADDI: acc = acc + imm;
            cpu_pkg::SUB:  acc = acc - data;
            cpu_pkg::SUBI: acc = acc - imm;
            default:       running = 1'b0;   // HLT and unused codes
         endcase
         if (running) pc++;
      end
      out_v = out_reg;
      pc_v  = cpu_pkg::pc_t'(pc);
   endtask

   task automatic build_table();
      logic [10:0]    r1;
      logic [10:0]    r2;
      logic [10:0]    r3;
      cpu_pkg::word_t eo;
      cpu_pkg::pc_t   ep;
      for (int t = 0; t < NUM_TESTS; t++) begin
         prog_len[t]   = 0;
         hold_check[t] = 1'b0;
         in_val[t]     = '0;
         for (int w = 0; w < PROG_MAX; w++) prog[t][w] = '0;
      end
      rand_operand(r1);
      rand_operand(r2);
      rand_operand(r3);
      test_name[0] = "arith_imm";
      emit(0, cpu_pkg::LDI, r1);
      emit(0, cpu_pkg::ADDI, r2);
      emit(0, cpu_pkg::SUBI, r3);
      emit(0, cpu_pkg::ADDI, 11'h7ff);  // Minus one
      emit(0, cpu_pkg::STO, 11'h400);
      emit(0, cpu_pkg::HLT, 11'h000);
      test_name[1] = "ram_roundtrip";
      emit(1, cpu_pkg::LDI, 11'h123);
      emit(1, cpu_pkg::STO, 11'h005);
      emit(1, cpu_pkg::LDI, 11'h7f9);
      emit(1, cpu_pkg::STO, 11'h00a);
      emit(1, cpu_pkg::LDI, 11'h3ff);
      emit(1, cpu_pkg::STO, 11'h3ff);   // Last RAM word
      emit(1, cpu_pkg::LDI, 11'h000);
      emit(1, cpu_pkg::LD, 11'h005);
      emit(1, cpu_pkg::ADD, 11'h00a);
      emit(1, cpu_pkg::SUB, 11'h3ff);
      emit(1, cpu_pkg::STO, 11'h400);
      emit(1, cpu_pkg::HLT, 11'h000);
      test_name[2] = "port_input";
      in_val[2]    = 16'ha5c3;
      emit(2, cpu_pkg::LDI, 11'h000);
      emit(2, cpu_pkg::LD, 11'h401);    // Wait-stated read
      emit(2, cpu_pkg::ADDI, 11'h025);
      emit(2, cpu_pkg::STO, 11'h400);
      emit(2, cpu_pkg::HLT, 11'h000);
      test_name[3] = "port_readback";
      in_val[3]    = 16'h1234;
      emit(3, cpu_pkg::LDI, 11'h2ab);
      emit(3, cpu_pkg::STO, 11'h400);
      emit(3, cpu_pkg::LDI, 11'h000);
      emit(3, cpu_pkg::LD, 11'h400);
      emit(3, cpu_pkg::ADDI, 11'h001);
      emit(3, cpu_pkg::STO, 11'h400);
      emit(3, cpu_pkg::HLT, 11'h000);
      test_name[4]  = "halt_and_reset";
      in_val[4]     = 16'h0f0f;
      hold_check[4] = 1'b1;
      emit(4, cpu_pkg::LDI, 11'h155);
      emit(4, cpu_pkg::SUBI, 11'h7ff);
      emit(4, cpu_pkg::STO, 11'h400);
      emit(4, cpu_pkg::HLT, 11'h000);
      emit(4, cpu_pkg::LDI, 11'h0aa);   // Never reached
      emit(4, cpu_pkg::STO, 11'h400);   // Would move the out port if execution ran past HLT
      for (int t = 0; t < NUM_TESTS; t++) begin
         model_run(t, eo, ep);
         exp_out[t] = eo;
         exp_pc[t]  = ep;
      end
   endtask

   // Falling edge, then present the word at the current PC
   task automatic tick();
      @(negedge clk);
      if (o_pc[10:4] == 7'd0) i_instr = prog[cur][o_pc[3:0]];
      else i_instr = '0;
   endtask

   task automatic apply_reset();
      i_reset = 1'b1;
      repeat (5) tick();
      i_reset = 1'b0;
   endtask

   task automatic report_mismatch(input string name, input string what,
                                  input cpu_pkg::word_t exp, input cpu_pkg::word_t act);
      mismatch_count++;
      $display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
   endtask

   task automatic check_hold_and_reset(input int t);
      repeat (10) begin
         tick();
         if (o_pc !== exp_pc[t])
            report_mismatch(test_name[t], "pc after halt", {5'd0, exp_pc[t]}, {5'd0, o_pc});
         if (o_out_port !== exp_out[t])
            report_mismatch(test_name[t], "out port after halt", exp_out[t], o_out_port);
         if (o_halted !== 1'b1)
            report_mismatch(test_name[t], "halted flag", 16'd1, {15'd0, o_halted});
      end
      apply_reset();
      if (o_out_port !== 16'd0)
         report_mismatch(test_name[t], "out port after reset", 16'd0, o_out_port);
      if (o_pc !== 11'd0)
         report_mismatch(test_name[t], "pc after reset", 16'd0, {5'd0, o_pc});
      if (o_halted !== 1'b0)
         report_mismatch(test_name[t], "halted after reset", 16'd0, {15'd0, o_halted});
   endtask

   initial begin : watchdog
      wait (cycle_limit != 0);
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("The run timed out after %0d cycles without finishing the tests", cycle_limit);
      $display("Errors: %0d mismatches, 1 timeouts", mismatch_count);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin : main
      int total;
      i_reset        = 1'b1;
      i_instr        = '0;
      i_in_port      = '0;
      cur            = 0;
      mismatch_count = 0;
      cycle_count    = 0;
      lfsr_q         = 32'he7d6;
      build_table();
      total = 50;
      for (int t = 0; t < NUM_TESTS; t++) total += prog_len[t] * 4 + 5; // Slowest is 4 cycles
      cycle_limit = total;
      for (int t = 0; t < NUM_TESTS; t++) begin
         cur       = t;
         i_in_port = in_val[t];
         apply_reset();
         while (!o_halted) tick();
         if (o_out_port !== exp_out[t])
            report_mismatch(test_name[t], "out port", exp_out[t], o_out_port);
         if (o_pc !== exp_pc[t])
            report_mismatch(test_name[t], "halt pc", {5'd0, exp_pc[t]}, {5'd0, o_pc});
         if (hold_check[t]) check_hold_and_reset(t);
      end
      $display("Errors: %0d mismatches, 0 timeouts", mismatch_count);
      if (mismatch_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
cpu_pkg.sv
cpu_ifs.sv
instr_decode.sv
acc_execute.sv
data_memory.sv
mem_io.sv
io_port_apb.sv
cpu_top.sv
tb_cpu_top.sv

// File: run.sh
#!/bin/sh
# Build the CPU testbench with Verilator, run it and scan the log for failure
verilator --binary --timing --assert --top-module tb_cpu_top -f vlog.f -Mdir obj_dir > build.log 2>&1 \
   && ./obj_dir/Vtb_cpu_top > sim.log 2>&1 \
   && ! grep -q "SOME TESTS FAILED" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
